//--- common/lsu_pkg.sv
package lsu_pkg;

    // datapath and address widths
    localparam int xlen          = 32;
    localparam int mem_addr_bits = 17;  // byte address bits into the data RAM

    // access mode codes
    localparam logic [2:0] mode_word   = 3'd1;
    localparam logic [2:0] mode_half   = 3'd2;  // sign-extended on load
    localparam logic [2:0] mode_byte   = 3'd3;  // sign-extended on load
    localparam logic [2:0] mode_half_u = 3'd4;  // zero-extended on load
    localparam logic [2:0] mode_byte_u = 3'd5;  // zero-extended on load

    // write-back select codes
    localparam logic [1:0] src_alu  = 2'd0;  // address
    localparam logic [1:0] src_mem  = 2'd1;  // loaded value
    localparam logic [1:0] src_link = 2'd2;  // address plus 4

endpackage

//--- logic/byte_counter.sv
`timescale 1ns/10ps

module byte_counter (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  logic [2:0] count,
    output logic [1:0] index,
    output logic       last
);

    logic running;

    // final byte when index reaches count - 1
    assign last = running && ({1'b0, index} == (count - 3'd1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            index   <= 2'd0;
            running <= 1'b0;
        end
        else if (start)
        begin
            index   <= 2'd0;
            running <= 1'b1;
        end
        else if (running)
        begin
            if (last)
                running <= 1'b0;  // hold index until next start
            else
                index <= index + 2'd1;
        end
    end

endmodule

//--- lsu/byte_ram.sv
`timescale 1ns/10ps

module byte_ram (
    input  logic                              clk,
    input  logic [lsu_pkg::mem_addr_bits-1:0] ram_addr,
    input  logic                              ram_we,
    input  logic [7:0]                        wbyte,
    output logic [7:0]                        rbyte
);

    logic [7:0] mem [0:(2**lsu_pkg::mem_addr_bits)-1];

    always_ff @(posedge clk)
    begin
        if (ram_we)
            mem[ram_addr] <= wbyte;
    end

    // registered read returns the old byte on a same-cycle write
    always_ff @(posedge clk)
    begin
        rbyte <= mem[ram_addr];
    end

endmodule

//--- lsu/byte_lane_unit.sv
`timescale 1ns/10ps

module byte_lane_unit (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     step_active,
    input  logic                     finish,
    input  logic [1:0]               index,
    input  logic [2:0]               count,
    input  logic [2:0]               mode_q,
    input  logic [1:0]               src_q,
    input  logic [lsu_pkg::xlen-1:0] addr_q,
    input  logic [lsu_pkg::xlen-1:0] wd,
    input  logic [7:0]               rbyte,
    output logic [7:0]               wbyte,
    output logic [lsu_pkg::xlen-1:0] result
);

    logic [lsu_pkg::xlen-1:0] wd_q;
    logic [lsu_pkg::xlen-1:0] shreg;
    logic [lsu_pkg::xlen-1:0] assembled;
    logic [lsu_pkg::xlen-1:0] loaded;
    logic [lsu_pkg::xlen-1:0] next_result;
    logic [2:0]               sel;
    logic                     lag_q;  // read data lags address by one cycle

    // store byte count-1-index, most significant byte at the base
    assign sel = count - 3'd1 - {1'b0, index};

    always_comb
    begin
        case (mode_q)
            lsu_pkg::mode_word,
            lsu_pkg::mode_half,
            lsu_pkg::mode_byte,
            lsu_pkg::mode_half_u,
            lsu_pkg::mode_byte_u: wbyte = wd_q[8*sel[1:0] +: 8];
            default:              wbyte = 8'h00;
        endcase
    end

    // wd tracks the input while idle, so it holds the value sampled with req
    always_ff @(posedge clk)
    begin
        if (!step_active && !finish)
            wd_q <= wd;
        if (lag_q)
            shreg <= {shreg[lsu_pkg::xlen-9:0], rbyte};
    end

    assign assembled = {shreg[lsu_pkg::xlen-9:0], rbyte};  // last byte arrives in finish

    always_comb
    begin
        case (mode_q)
            lsu_pkg::mode_word:   loaded = assembled;
            lsu_pkg::mode_half:   loaded = {{16{assembled[15]}}, assembled[15:0]};
            lsu_pkg::mode_byte:   loaded = {{24{assembled[7]}}, assembled[7:0]};
            lsu_pkg::mode_half_u: loaded = {16'h0000, assembled[15:0]};
            lsu_pkg::mode_byte_u: loaded = {24'h000000, assembled[7:0]};
            default:              loaded = '0;
        endcase
    end

    always_comb
    begin
        case (src_q)
            lsu_pkg::src_alu:  next_result = addr_q;
            lsu_pkg::src_mem:  next_result = loaded;
            lsu_pkg::src_link: next_result = addr_q + lsu_pkg::xlen'(4);
            default:           next_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lag_q  <= 1'b0;
            result <= '0;
        end
        else
        begin
            lag_q <= step_active;
            if (finish)
                result <= next_result;  // held until the next finish
        end
    end

endmodule

//--- lsu/lsu_ctrl.sv
`timescale 1ns/10ps

module lsu_ctrl (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            req,
    input  logic                            we,
    input  logic [2:0]                      mode,
    input  logic [1:0]                      result_src,
    input  logic [lsu_pkg::xlen-1:0]        addr,
    input  logic                            last,
    output logic                            start,
    output logic [lsu_pkg::mem_addr_bits-1:0] ram_addr,
    output logic                            ram_we,
    output logic                            step_active,
    output logic                            finish,
    output logic                            busy,
    output logic                            done,
    output logic [2:0]                      mode_q,
    output logic [1:0]                      src_q,
    output logic [lsu_pkg::xlen-1:0]        addr_q,
    output logic [2:0]                      count
);

    logic access_q;  // state access
    logic finish_q;  // state finish, idle when neither is set
    logic we_q;
    logic accept;
    logic is_mem;
    logic [2:0] count_d;

    assign accept = req && !busy;  // strobes while busy are dropped
    assign is_mem = we || (result_src == lsu_pkg::src_mem);
    assign start  = accept && is_mem;

    always_comb
    begin
        case (mode)
            lsu_pkg::mode_word:   count_d = 3'd4;
            lsu_pkg::mode_half:   count_d = 3'd2;
            lsu_pkg::mode_half_u: count_d = 3'd2;
            default:              count_d = 3'd1;  // bytes and unknown codes
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            access_q <= 1'b0;
            finish_q <= 1'b0;
            done     <= 1'b0;
        end
        else
        begin
            done <= finish_q;  // one pulse on leaving finish
            if (accept)
            begin
                access_q <= is_mem;
                finish_q <= !is_mem;
            end
            else if (access_q && last)
            begin
                access_q <= 1'b0;
                finish_q <= 1'b1;
            end
            else if (finish_q)
            begin
                finish_q <= 1'b0;
            end
        end
    end

    // request fields and the running byte address
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            we_q     <= we;
            mode_q   <= mode;
            src_q    <= result_src;
            addr_q   <= addr;
            count    <= count_d;
            ram_addr <= {addr[lsu_pkg::mem_addr_bits-1:2], 2'b00};  // word base
        end
        else if (access_q)
        begin
            ram_addr <= ram_addr + lsu_pkg::mem_addr_bits'(1);
        end
    end

    assign ram_we      = access_q && we_q;
    assign step_active = access_q;
    assign finish      = finish_q;
    assign busy        = access_q || finish_q || done;

endmodule

//--- lsu/lsu_top.sv
`timescale 1ns/10ps

module lsu_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     req,
    input  logic                     we,
    input  logic [2:0]               mode,
    input  logic [1:0]               result_src,
    input  logic [lsu_pkg::xlen-1:0] addr,
    input  logic [lsu_pkg::xlen-1:0] wd,
    output logic                     busy,
    output logic                     done,
    output logic [lsu_pkg::xlen-1:0] result
);

    logic                              start;
    logic                              last;
    logic [1:0]                        index;
    logic [lsu_pkg::mem_addr_bits-1:0] ram_addr;
    logic                              ram_we;
    logic [7:0]                        wbyte;
    logic [7:0]                        rbyte;
    logic                              step_active;
    logic                              finish;
    logic [2:0]                        mode_q;
    logic [1:0]                        src_q;
    logic [lsu_pkg::xlen-1:0]          addr_q;
    logic [2:0]                        count;

    lsu_ctrl ctrl0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .we          (we),
        .mode        (mode),
        .result_src  (result_src),
        .addr        (addr),
        .last        (last),
        .start       (start),
        .ram_addr    (ram_addr),
        .ram_we      (ram_we),
        .step_active (step_active),
        .finish      (finish),
        .busy        (busy),
        .done        (done),
        .mode_q      (mode_q),
        .src_q       (src_q),
        .addr_q      (addr_q),
        .count       (count)
    );

    byte_counter cnt0 (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .count  (count),
        .index  (index),
        .last   (last)
    );

    byte_ram ram0 (
        .clk      (clk),
        .ram_addr (ram_addr),
        .ram_we   (ram_we),
        .wbyte    (wbyte),
        .rbyte    (rbyte)
    );

    byte_lane_unit lane0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .step_active (step_active),
        .finish      (finish),
        .index       (index),
        .count       (count),
        .mode_q      (mode_q),
        .src_q       (src_q),
        .addr_q      (addr_q),
        .wd          (wd),
        .rbyte       (rbyte),
        .wbyte       (wbyte),
        .result      (result)
    );

endmodule

//--- tb/lsu_properties.sv
`timescale 1ns/10ps

module lsu_properties (
    input logic clk,
    input logic arst_n,
    input logic req,
    input logic ram_we,
    input logic busy,
    input logic done
);

    no_req_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
        req |-> !busy)
        else $error("request strobe while busy");

    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done held for more than one cycle");

    busy_clears_after_done: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !busy)
        else $error("busy still high after done");

    // writes only in the access state
    write_inside_access: assert property (@(posedge clk) disable iff (!arst_n)
        ram_we |-> (busy && !done))
        else $error("ram write outside an access");

    busy_ends_at_done: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(done))
        else $error("busy dropped without done");

endmodule

bind lsu_top lsu_properties props0 (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .ram_we (ram_we),
    .busy   (busy),
    .done   (done)
);

//--- tb/lsu_tb.sv
`timescale 1ns/10ps

module lsu_tb;

    localparam int num_random  = 200;
    localparam int cycle_limit = 3000;  // 200 random ops at 6 cycles plus directed

    logic                     clk;
    logic                     arst_n;
    logic                     req;
    logic                     we;
    logic [2:0]               mode;
    logic [1:0]               result_src;
    logic [lsu_pkg::xlen-1:0] addr;
    logic [lsu_pkg::xlen-1:0] wd;
    logic                     busy;
    logic                     done;
    logic [lsu_pkg::xlen-1:0] result;

    logic [7:0]  mem_model [int];  // byte model keyed by 17-bit address
    logic [31:0] lcg_state;
    int          cycle_count;

    lsu_top dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .we         (we),
        .mode       (mode),
        .result_src (result_src),
        .addr       (addr),
        .wd         (wd),
        .busy       (busy),
        .done       (done),
        .result     (result)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $fatal(1, "cycle limit reached");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int base_of(input logic [31:0] a);
        return int'({a[16:2], 2'b00});  // low two bits dropped
    endfunction

    function automatic logic [7:0] model_byte(input int a);
        if (mem_model.exists(a))
            return mem_model[a];
        else
            return 8'h00;
    endfunction

    function automatic int byte_count(input logic [2:0] md);
        case (md)
            lsu_pkg::mode_word:                       return 4;
            lsu_pkg::mode_half, lsu_pkg::mode_half_u: return 2;
            default:                                  return 1;
        endcase
    endfunction

    // most significant byte at the lowest address
    task automatic model_store(input logic [2:0] md, input logic [31:0] a, input logic [31:0] d);
        int b;
        b = base_of(a);
        case (md)
            lsu_pkg::mode_word:
            begin
                mem_model[b]     = d[31:24];
                mem_model[b + 1] = d[23:16];
                mem_model[b + 2] = d[15:8];
                mem_model[b + 3] = d[7:0];
            end
            lsu_pkg::mode_half, lsu_pkg::mode_half_u:
            begin
                mem_model[b]     = d[15:8];
                mem_model[b + 1] = d[7:0];
            end
            lsu_pkg::mode_byte, lsu_pkg::mode_byte_u:
                mem_model[b] = d[7:0];
            default:
                mem_model[b] = 8'h00;
        endcase
    endtask

    function automatic logic [31:0] model_load(input logic [2:0] md, input logic [31:0] a);
        int          b;
        logic [15:0] h;
        logic [7:0]  y;
        b = base_of(a);
        h = {model_byte(b), model_byte(b + 1)};
        y = model_byte(b);
        case (md)
            lsu_pkg::mode_word:   return {h, model_byte(b + 2), model_byte(b + 3)};
            lsu_pkg::mode_half:   return {{16{h[15]}}, h};
            lsu_pkg::mode_byte:   return {{24{y[7]}}, y};
            lsu_pkg::mode_half_u: return {16'h0000, h};
            lsu_pkg::mode_byte_u: return {24'h000000, y};
            default:              return 32'h0000_0000;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_busy(input string name);
        assert (busy === 1'b1)
        else
        begin
            $display("busy went low before done during %s", name);
            $display("TESTS FAILED");
            $fatal(1, "busy dropped early");
        end
    endtask

    // one request, then wait for done and check latency and result
    task automatic run_op(input string name, input logic wr, input logic [2:0] md,
                          input logic [1:0] src, input logic [31:0] a, input logic [31:0] d);
        logic [31:0] expected;
        int          latency;
        int          cycles;
        if (src == lsu_pkg::src_link)
            expected = a + 32'd4;
        else if (src == lsu_pkg::src_mem && !wr)
            expected = model_load(md, a);
        else
            expected = a;
        if (wr || src == lsu_pkg::src_mem)
            latency = byte_count(md) + 1;
        else
            latency = 1;
        if (wr)
            model_store(md, a, d);
        req        = 1'b1;
        we         = wr;
        mode       = md;
        result_src = src;
        addr       = a;
        wd         = d;
        @(posedge clk);
        #1;
        req    = 1'b0;
        cycles = 0;
        while (done !== 1'b1)
        begin
            check_busy(name);
            @(posedge clk);
            #1;
            cycles++;
        end
        check_busy(name);
        check_word({name, " latency"}, 32'(latency), 32'(cycles));
        check_word(name, expected, result);
        @(posedge clk);  // done cycle still counts as busy
        #1;
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] a;
        lcg_state  = 32'd72;
        arst_n     = 1'b0;
        req        = 1'b0;
        we         = 1'b0;
        mode       = lsu_pkg::mode_word;
        result_src = lsu_pkg::src_alu;
        addr       = '0;
        wd         = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_word("reset busy", 32'd0, {31'd0, busy});
        check_word("reset done", 32'd0, {31'd0, done});
        check_word("reset result", 32'd0, result);

        run_op("word store", 1'b1, lsu_pkg::mode_word, lsu_pkg::src_alu, 32'h200, 32'hA1B2_C3D4);
        run_op("word load", 1'b0, lsu_pkg::mode_word, lsu_pkg::src_mem, 32'h200, 32'h0);
        run_op("byte order", 1'b0, lsu_pkg::mode_byte, lsu_pkg::src_mem, 32'h203, 32'h0);
        run_op("half store", 1'b1, lsu_pkg::mode_half, lsu_pkg::src_alu, 32'h201, 32'h1234_8E7F);
        run_op("word after half", 1'b0, lsu_pkg::mode_word, lsu_pkg::src_mem, 32'h200, 32'h0);
        run_op("half load neg", 1'b0, lsu_pkg::mode_half, lsu_pkg::src_mem, 32'h202, 32'h0);
        run_op("half_u load neg", 1'b0, lsu_pkg::mode_half_u, lsu_pkg::src_mem, 32'h203, 32'h0);
        run_op("byte store", 1'b1, lsu_pkg::mode_byte_u, lsu_pkg::src_link, 32'h202, 32'h55);
        run_op("byte load pos", 1'b0, lsu_pkg::mode_byte, lsu_pkg::src_mem, 32'h201, 32'h0);
        run_op("word after byte", 1'b0, lsu_pkg::mode_word, lsu_pkg::src_mem, 32'h200, 32'h0);
        run_op("half store pos", 1'b1, lsu_pkg::mode_half_u, lsu_pkg::src_alu, 32'h300, 32'h7ABC);
        run_op("half load pos", 1'b0, lsu_pkg::mode_half, lsu_pkg::src_mem, 32'h301, 32'h0);
        run_op("byte store neg", 1'b1, lsu_pkg::mode_byte, lsu_pkg::src_alu, 32'h304, 32'hF0);
        run_op("byte load neg", 1'b0, lsu_pkg::mode_byte, lsu_pkg::src_mem, 32'h306, 32'h0);
        run_op("byte_u load neg", 1'b0, lsu_pkg::mode_byte_u, lsu_pkg::src_mem, 32'h305, 32'h0);
        run_op("unknown store", 1'b1, 3'd7, lsu_pkg::src_alu, 32'h200, 32'hFFFF_FFFF);
        run_op("word after unknown", 1'b0, lsu_pkg::mode_word, lsu_pkg::src_mem, 32'h200, 32'h0);
        run_op("unknown load", 1'b0, 3'd0, lsu_pkg::src_mem, 32'h300, 32'h0);
        run_op("alu result", 1'b0, lsu_pkg::mode_word, lsu_pkg::src_alu, 32'hDEAD_BEEF, 32'h0);
        run_op("link result", 1'b0, lsu_pkg::mode_byte, lsu_pkg::src_link, 32'hFFFF_FFFE, 32'h0);

        // fill the random region so every load hits written bytes
        for (int i = 0; i < 16; i++)
        begin
            r = lcg_next();
            d = lcg_next();
            a = {r[31:17], 11'h404, 4'(i), r[1:0]};
            run_op("preload", 1'b1, lsu_pkg::mode_word, lsu_pkg::src_alu, a, d);
        end

        for (int i = 0; i < num_random; i++)
        begin
            r = lcg_next();
            d = lcg_next();
            a = {r[31:17], 11'h404, r[5:0]};  // 16 word bases near 0x10100
            case (r[16:15])
                2'd0:
                    run_op($sformatf("random store %0d", i), 1'b1, r[13:11],
                           r[14] ? lsu_pkg::src_link : lsu_pkg::src_alu, a, d);
                2'd3:
                    run_op($sformatf("random nonmem %0d", i), 1'b0, r[13:11],
                           r[14] ? lsu_pkg::src_link : lsu_pkg::src_alu, a, d);
                default:
                    run_op($sformatf("random load %0d", i), 1'b0, r[13:11],
                           lsu_pkg::src_mem, a, d);
            endcase
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- list.f
common/lsu_pkg.sv
logic/byte_counter.sv
lsu/byte_ram.sv
lsu/byte_lane_unit.sv
lsu/lsu_ctrl.sv
lsu/lsu_top.sv
tb/lsu_properties.sv
tb/lsu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the lsu testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f --top-module lsu_tb -o lsu_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/lsu_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
